/* build.f */
hw/exu_pkg.sv
hw/exu_regfile.sv
hw/exu_alu.sv
hw/exu_bru.sv
hw/exu_wb.sv
hw/exu.sv
testbench/exu_checker.sv
testbench/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - files:
      - hw/exu_pkg.sv
      - hw/exu_regfile.sv
      - hw/exu_alu.sv
      - hw/exu_bru.sv
      - hw/exu_wb.sv
      - hw/exu.sv
  - target: test
    files:
      - testbench/exu_checker.sv
      - testbench/exu_tb.sv

/* testbench/exu_tb.sv */
`default_nettype none

module exu_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned N_TESTS = 6;

   logic                clk;
   logic                rst_n;
   exu_pkg::exu_issue_t issue;
   exu_pkg::reg_idx_t   rs1_d;
   exu_pkg::reg_idx_t   rs2_d;
   exu_pkg::grlen_t     rs1_data_d;
   exu_pkg::grlen_t     rs2_data_d;
   exu_pkg::grlen_t     brpc_e;
   logic                br_taken_e;

   // expected register file contents
   exu_pkg::grlen_t shadow [0:31];

   exu u_exu (
      .clk        (clk        ),
      .rst_n      (rst_n      ),
      .issue      (issue      ),
      .rs1_d      (rs1_d      ),
      .rs2_d      (rs2_d      ),
      .rs1_data_d (rs1_data_d ),
      .rs2_data_d (rs2_data_d ),
      .brpc_e     (brpc_e     ),
      .br_taken_e (br_taken_e )
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      #(N_TESTS * 200 * 8);
      $display("timeout: the tests did not complete within %0d cycles", N_TESTS * 200);
      $display("TESTS FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      wait (u_exu.u_checker.assert_fails != 0);
      $display("a concurrent assertion in the bound checker failed");
      $display("TESTS FAILED");
      $fatal(1, "assertion failed");
   end

   task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
      if (actual !== expected) begin
         $display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic expect_reg(input exu_pkg::reg_idx_t idx, input exu_pkg::grlen_t exp,
                             input string what);
      rs1_d = idx;
      rs2_d = idx;
      #1;
      check_eq(rs1_data_d, exp, {what, " rs1"});
      check_eq(rs2_data_d, exp, {what, " rs2"});
   endtask

   function automatic exu_pkg::grlen_t alu_expect(exu_pkg::alu_op_e op, exu_pkg::grlen_t a,
                                                  exu_pkg::grlen_t b);
      exu_pkg::grlen_t r;
      int unsigned     s;
      s = b % 32;
      case (op)
         exu_pkg::ALU_ADD:  r = a + b;
         exu_pkg::ALU_SUB:  r = a + ~b + 32'd1;
         // flipping the sign bits turns a signed compare into an unsigned one
         exu_pkg::ALU_SLT:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
         exu_pkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
         exu_pkg::ALU_AND:  r = a & b;
         exu_pkg::ALU_OR:   r = a | b;
         exu_pkg::ALU_XOR:  r = a ^ b;
         exu_pkg::ALU_NOR:  r = ~a & ~b;
         exu_pkg::ALU_SLL:  r = a << s;
         exu_pkg::ALU_SRL:  r = a >> s;
         exu_pkg::ALU_SRA:  r = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'd0);
         default:           r = b;
      endcase
      return r;
   endfunction

   function automatic bit branch_expect(exu_pkg::bru_op_e op, exu_pkg::grlen_t a,
                                        exu_pkg::grlen_t b);
      bit lt_s;
      lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
      case (op)
         exu_pkg::BRU_BEQ:  return a == b;
         exu_pkg::BRU_BNE:  return a != b;
         exu_pkg::BRU_BLT:  return lt_s;
         exu_pkg::BRU_BGE:  return !lt_s;
         exu_pkg::BRU_BLTU: return a < b;
         exu_pkg::BRU_BGEU: return !(a < b);
         default:           return 1'b1;
      endcase
   endfunction

   function automatic exu_pkg::exu_issue_t alu_issue(exu_pkg::alu_op_e op, exu_pkg::grlen_t a,
                                                     exu_pkg::grlen_t b, exu_pkg::reg_idx_t rd);
      exu_pkg::exu_issue_t i;
      i = '0;
      i.valid = 1'b1;
      i.alu_a = a;
      i.alu_b = b;
      i.alu_op = op;
      i.rf_target = rd;
      i.alu_wen = 1'b1;
      return i;
   endfunction

   function automatic exu_pkg::exu_issue_t bru_issue(exu_pkg::bru_op_e op, exu_pkg::grlen_t pc,
                                                     exu_pkg::grlen_t a, exu_pkg::grlen_t b,
                                                     exu_pkg::grlen_t off, exu_pkg::reg_idx_t rd);
      exu_pkg::exu_issue_t i;
      i = '0;
      i.valid = 1'b1;
      i.pc = pc;
      i.alu_a = a;
      i.alu_b = b;
      i.rf_target = rd;
      i.bru_valid = 1'b1;
      i.bru_op = op;
      i.bru_offset = off;
      return i;
   endfunction

   // issue in cycle n, old value in n+1, new value from n+2
   task automatic write_and_check(input exu_pkg::exu_issue_t iss, input exu_pkg::reg_idx_t rd,
                                  input exu_pkg::grlen_t exp, input string what);
      issue = iss;
      step();
      issue = '0;
      expect_reg(rd, shadow[rd], {what, " before write"});
      step();
      expect_reg(rd, exp, what);
      shadow[rd] = exp;
   endtask

   task automatic reset_clears_regs();
      for (int r = 0; r < 32; r++) begin
         step();
         expect_reg(exu_pkg::reg_idx_t'(r), '0, "reset value");
      end
   endtask

   task automatic alu_ops_write_back();
      exu_pkg::alu_op_e  op;
      exu_pkg::grlen_t   a;
      exu_pkg::grlen_t   b;
      exu_pkg::reg_idx_t rd;
      for (int k = 0; k < 12; k++) begin
         for (int n = 0; n < 3; n++) begin
            op = exu_pkg::alu_op_e'(k);
            a = $urandom;
            b = (n == 0) ? a : $urandom;
            rd = exu_pkg::reg_idx_t'(($urandom % 31) + 1);
            write_and_check(alu_issue(op, a, b, rd), rd, alu_expect(op, a, b), op.name());
         end
      end
   endtask

   task automatic zero_reg_and_invalid();
      exu_pkg::exu_issue_t i;
      write_and_check(alu_issue(exu_pkg::ALU_ADD, $urandom, 32'd1, 5'd0), 5'd0, '0, "r0 write");
      write_and_check(alu_issue(exu_pkg::ALU_LUI, '0, 32'h1234_5678, 5'd7), 5'd7,
                      32'h1234_5678, "r7 setup");
      i = alu_issue(exu_pkg::ALU_LUI, '0, 32'hdead_beef, 5'd7);
      i.valid = 1'b0;
      write_and_check(i, 5'd7, 32'h1234_5678, "invalid issue");
   endtask

   task automatic cond_branches();
      exu_pkg::bru_op_e op;
      exu_pkg::grlen_t  a;
      exu_pkg::grlen_t  b;
      exu_pkg::grlen_t  pc;
      exu_pkg::grlen_t  off;
      for (int k = 0; k < 6; k++) begin
         for (int n = 0; n < 5; n++) begin
            op = exu_pkg::bru_op_e'(k);
            a = $urandom;
            pc = $urandom;
            off = $urandom;
            // equal pair, then a pair that differs only in the sign bit
            b = (n == 0) ? a : (n == 1) ? (a ^ 32'h8000_0000) : $urandom;
            issue = bru_issue(op, pc, a, b, off, 5'd0);
            #1;
            check_eq(br_taken_e, branch_expect(op, a, b), {op.name(), " taken"});
            check_eq(brpc_e, pc + off, {op.name(), " target"});
            step();
            issue.bru_valid = 1'b0;
            #1;
            check_eq(br_taken_e, 1'b0, {op.name(), " without bru_valid"});
            step();
         end
      end
      issue = '0;
   endtask

   task automatic links_and_jumps();
      exu_pkg::grlen_t a;
      exu_pkg::grlen_t pc;
      exu_pkg::grlen_t off;
      pc = $urandom;
      off = $urandom;
      issue = bru_issue(exu_pkg::BRU_BL, pc, $urandom, $urandom, off, 5'd3);
      #1;
      check_eq(br_taken_e, 1'b1, "bl taken");
      check_eq(brpc_e, pc + off, "bl target");
      write_and_check(issue, 5'd3, pc + 32'd4, "bl link");
      a = $urandom;
      pc = $urandom;
      off = $urandom;
      issue = bru_issue(exu_pkg::BRU_JIRL, pc, a, $urandom, off, 5'd30);
      #1;
      check_eq(br_taken_e, 1'b1, "jirl taken");
      check_eq(brpc_e, a + off, "jirl target");
      write_and_check(issue, 5'd30, pc + 32'd4, "jirl link");
   endtask

   task automatic back_to_back_issue();
      exu_pkg::reg_idx_t tgt [0:3];
      exu_pkg::grlen_t   val [0:3];
      exu_pkg::grlen_t   a;
      exu_pkg::grlen_t   b;
      for (int c = 0; c < 6; c++) begin
         if (c < 4) begin
            a = $urandom;
            b = $urandom;
            tgt[c] = exu_pkg::reg_idx_t'(10 + c);
            val[c] = a ^ b;
            issue = alu_issue(exu_pkg::ALU_XOR, a, b, tgt[c]);
         end else begin
            issue = '0;
         end
         if (c >= 2) begin
            expect_reg(tgt[c-2], val[c-2], "back-to-back");
            shadow[tgt[c-2]] = val[c-2];
         end
         step();
      end
   endtask

   initial begin
      void'($urandom(76));
      rst_n = 1'b0;
      issue = '0;
      rs1_d = '0;
      rs2_d = '0;
      for (int r = 0; r < 32; r++) begin
         shadow[r] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      reset_clears_regs();
      alu_ops_write_back();
      zero_reg_and_invalid();
      cond_branches();
      links_and_jumps();
      back_to_back_issue();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/exu_checker.sv */
`default_nettype none

module exu_checker (
   input wire logic                clk,
   input wire logic                rst_n,
   input wire exu_pkg::exu_issue_t issue,
   input wire logic                br_taken_e,
   input wire exu_pkg::wb_t        wb,
   input wire exu_pkg::reg_idx_t   rs1_d,
   input wire exu_pkg::reg_idx_t   rs2_d,
   input wire exu_pkg::grlen_t     rs1_data_d,
   input wire exu_pkg::grlen_t     rs2_data_d
);

   timeunit 1ns;
   timeprecision 1ps;

   int unsigned assert_fails = 0;

   redirect_needs_branch: assert property (@(posedge clk)
      br_taken_e |-> (issue.valid && issue.bru_valid))
      else begin
         $error("branch taken without a valid branch issue");
         assert_fails++;
      end

   // wb stage must come out of reset empty
   no_write_after_reset: assert property (@(posedge clk) !rst_n |=> !wb.wen)
      else begin
         $error("write port enabled right after reset");
         assert_fails++;
      end

   r0_reads_zero_rs1: assert property (@(posedge clk) (rs1_d == '0) |-> (rs1_data_d == '0))
      else begin
         $error("register 0 read nonzero on rs1");
         assert_fails++;
      end

   r0_reads_zero_rs2: assert property (@(posedge clk) (rs2_d == '0) |-> (rs2_data_d == '0))
      else begin
         $error("register 0 read nonzero on rs2");
         assert_fails++;
      end

endmodule

bind exu exu_checker u_checker (.*);

`default_nettype wire

/* hw/exu.sv */
`default_nettype none

module exu (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire exu_pkg::exu_issue_t issue,
   input  wire exu_pkg::reg_idx_t   rs1_d,
   input  wire exu_pkg::reg_idx_t   rs2_d,
   output exu_pkg::grlen_t          rs1_data_d,
   output exu_pkg::grlen_t          rs2_data_d,
   output exu_pkg::grlen_t          brpc_e,
   output logic                     br_taken_e
);

   exu_pkg::grlen_t  alu_res;
   exu_pkg::br_res_t br_res;
   exu_pkg::wb_t     wb;

   // read ports serve decode, write port fed from wb stage
   exu_regfile u_regfile (
      .clk        (clk        ),
      .rst_n      (rst_n      ),
      .rs1_d      (rs1_d      ),
      .rs2_d      (rs2_d      ),
      .wb         (wb         ),
      .rs1_data_d (rs1_data_d ),
      .rs2_data_d (rs2_data_d )
   );

   exu_alu u_alu (
      .a   (issue.alu_a  ),
      .b   (issue.alu_b  ),
      .op  (issue.alu_op ),
      .res (alu_res      )
   );

   exu_bru u_bru (
      .issue  (issue  ),
      .br_res (br_res )
   );

   exu_wb u_wb (
      .clk     (clk     ),
      .rst_n   (rst_n   ),
      .issue   (issue   ),
      .alu_res (alu_res ),
      .br_res  (br_res  ),
      .wb      (wb      )
   );

   // redirect goes back to fetch in the same cycle
   assign brpc_e     = br_res.target;
   assign br_taken_e = br_res.taken;

endmodule

`default_nettype wire

/* hw/exu_wb.sv */
`default_nettype none

module exu_wb (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire exu_pkg::exu_issue_t issue,
   input  wire exu_pkg::grlen_t     alu_res,
   input  wire exu_pkg::br_res_t    br_res,
   output exu_pkg::wb_t             wb
);

   logic              wen_e;
   exu_pkg::grlen_t   data_e;
   logic              wen_q;
   exu_pkg::reg_idx_t rd_q;
   exu_pkg::grlen_t   data_q;

   // link already carries valid and bru_valid
   assign wen_e  = issue.valid & (issue.alu_wen | br_res.link);
   assign data_e = br_res.link ? br_res.link_pc : alu_res;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wen_q <= 1'b0;
      end else begin
         wen_q <= wen_e;
      end
   end

   always_ff @(posedge clk) begin
      rd_q   <= issue.rf_target;
      data_q <= data_e;
   end

   always_comb begin
      wb.wen  = wen_q;
      wb.rd   = rd_q;
      wb.data = data_q;
   end

endmodule

`default_nettype wire

/* hw/exu_bru.sv */
`default_nettype none

module exu_bru (
   input  wire exu_pkg::exu_issue_t issue,
   output exu_pkg::br_res_t         br_res
);

   logic            active;
   logic            cond;
   logic            is_link;
   exu_pkg::grlen_t base;

   assign active = issue.valid & issue.bru_valid;

   always_comb begin
      unique case (issue.bru_op)
         exu_pkg::BRU_BEQ:  cond = issue.alu_a == issue.alu_b;
         exu_pkg::BRU_BNE:  cond = issue.alu_a != issue.alu_b;
         exu_pkg::BRU_BLT:  cond = $signed(issue.alu_a) < $signed(issue.alu_b);
         exu_pkg::BRU_BGE:  cond = $signed(issue.alu_a) >= $signed(issue.alu_b);
         exu_pkg::BRU_BLTU: cond = issue.alu_a < issue.alu_b;
         exu_pkg::BRU_BGEU: cond = issue.alu_a >= issue.alu_b;
         exu_pkg::BRU_B,
         exu_pkg::BRU_BL,
         exu_pkg::BRU_JIRL: cond = 1'b1;
         default:           cond = 1'b0;
      endcase
   end

   assign is_link = (issue.bru_op == exu_pkg::BRU_BL) ||
                    (issue.bru_op == exu_pkg::BRU_JIRL);

   // jirl is register relative, the rest pc relative
   assign base = (issue.bru_op == exu_pkg::BRU_JIRL) ? issue.alu_a : issue.pc;

   always_comb begin
      if (active) begin
         br_res.taken   = cond;
         br_res.target  = base + issue.bru_offset;
         br_res.link    = is_link;
         br_res.link_pc = issue.pc + 32'd4;
      end else begin
         br_res = '0;
      end
   end

endmodule

`default_nettype wire

/* hw/exu_alu.sv */
`default_nettype none

module exu_alu (
   input  wire exu_pkg::grlen_t  a,
   input  wire exu_pkg::grlen_t  b,
   input  wire exu_pkg::alu_op_e op,
   output exu_pkg::grlen_t       res
);

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   // only the low bits of b shift
   assign shamt = b[4:0];

   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      unique case (op)
         exu_pkg::ALU_ADD: begin
            res = a + b;
         end
         exu_pkg::ALU_SUB: begin
            res = a - b;
         end
         exu_pkg::ALU_SLT: begin
            res = {31'd0, lt_signed};
         end
         exu_pkg::ALU_SLTU: begin
            res = {31'd0, lt_unsigned};
         end
         exu_pkg::ALU_AND: begin
            res = a & b;
         end
         exu_pkg::ALU_OR: begin
            res = a | b;
         end
         exu_pkg::ALU_XOR: begin
            res = a ^ b;
         end
         exu_pkg::ALU_NOR: begin
            res = ~(a | b);
         end
         exu_pkg::ALU_SLL: begin
            res = a << shamt;
         end
         exu_pkg::ALU_SRL: begin
            res = a >> shamt;
         end
         exu_pkg::ALU_SRA: begin
            res = $signed(a) >>> shamt;
         end
         // immediate already shifted upstream
         exu_pkg::ALU_LUI: begin
            res = b;
         end
         default: begin
            res = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/exu_regfile.sv */
`default_nettype none

module exu_regfile (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire exu_pkg::reg_idx_t rs1_d,
   input  wire exu_pkg::reg_idx_t rs2_d,
   input  wire exu_pkg::wb_t      wb,
   output exu_pkg::grlen_t        rs1_data_d,
   output exu_pkg::grlen_t        rs2_data_d
);

   // r0 has no storage
   exu_pkg::grlen_t regs [1:31];

   logic wr_en;

   assign wr_en = wb.wen && (wb.rd != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // no write-through, a result shows up the cycle after the write
   always_comb begin
      if (rs1_d == '0) begin
         rs1_data_d = '0;
      end else begin
         rs1_data_d = regs[rs1_d];
      end
   end

   always_comb begin
      if (rs2_d == '0) begin
         rs2_data_d = '0;
      end else begin
         rs2_data_d = regs[rs2_d];
      end
   end

endmodule

`default_nettype wire

/* hw/exu_pkg.sv */
`default_nettype none

package exu_pkg;

   localparam int unsigned GRLEN = 32;
   localparam int unsigned REG_IDX_W = 5;

   typedef logic [GRLEN-1:0] grlen_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_SLTU = 4'd3,
      ALU_AND  = 4'd4,
      ALU_OR   = 4'd5,
      ALU_XOR  = 4'd6,
      ALU_NOR  = 4'd7,
      ALU_SLL  = 4'd8,
      ALU_SRL  = 4'd9,
      ALU_SRA  = 4'd10,
      ALU_LUI  = 4'd11
   } alu_op_e;

   typedef enum logic [3:0] {
      BRU_BEQ  = 4'd0,
      BRU_BNE  = 4'd1,
      BRU_BLT  = 4'd2,
      BRU_BGE  = 4'd3,
      BRU_BLTU = 4'd4,
      BRU_BGEU = 4'd5,
      BRU_B    = 4'd6,
      BRU_BL   = 4'd7,
      BRU_JIRL = 4'd8
   } bru_op_e;

   // operands arrive already muxed by decode
   typedef struct packed {
      logic     valid;
      grlen_t   pc;
      grlen_t   alu_a;
      grlen_t   alu_b;
      alu_op_e  alu_op;
      reg_idx_t rf_target;
      logic     alu_wen;
      logic     bru_valid;
      bru_op_e  bru_op;
      grlen_t   bru_offset;
   } exu_issue_t;

   typedef struct packed {
      logic   taken;
      grlen_t target;
      logic   link;
      grlen_t link_pc;
   } br_res_t;

   typedef struct packed {
      logic     wen;
      reg_idx_t rd;
      grlen_t   data;
   } wb_t;

endpackage

`default_nettype wire
